// ==== design/la32_macros.svh ====
`ifndef LA32_MACROS_SVH
`define LA32_MACROS_SVH

`define LA32_XLEN   32
`define LA32_REG_AW 5
`define LA32_NREGS  32

// Instruction fields
`define LA32_F_RD   4:0
`define LA32_F_RJ   9:5
`define LA32_F_RK   14:10
`define LA32_F_UI5  14:10
`define LA32_F_SI12 21:10
`define LA32_F_SI20 24:5

// Leading opcode bits compared per format
`define LA32_LEN_3R    17
`define LA32_LEN_2RI12 10
`define LA32_LEN_1RI20 7

`define LA32_OP_ADD_W   32'h0010_0000
`define LA32_OP_SUB_W   32'h0011_0000
`define LA32_OP_SLT     32'h0012_0000
`define LA32_OP_SLTU    32'h0012_8000
`define LA32_OP_NOR     32'h0014_0000
`define LA32_OP_AND     32'h0014_8000
`define LA32_OP_OR      32'h0015_0000
`define LA32_OP_XOR     32'h0015_8000
`define LA32_OP_SLL_W   32'h0017_0000
`define LA32_OP_SRL_W   32'h0017_8000
`define LA32_OP_SRA_W   32'h0018_0000
// Immediate shifts use the 3R opcode length
`define LA32_OP_SLLI_W  32'h0040_8000
`define LA32_OP_SRLI_W  32'h0044_8000
`define LA32_OP_SRAI_W  32'h0048_8000
`define LA32_OP_SLTI    32'h0200_0000
`define LA32_OP_SLTUI   32'h0240_0000
`define LA32_OP_ADDI_W  32'h0280_0000
`define LA32_OP_ANDI    32'h0340_0000
`define LA32_OP_ORI     32'h0380_0000
`define LA32_OP_XORI    32'h03c0_0000
`define LA32_OP_LU12I_W 32'h1400_0000

`endif

// ==== design/la32_pkg.sv ====
`default_nettype none

`include "la32_macros.svh"

package la32_pkg;

  typedef logic [`LA32_XLEN-1:0] word_t;

  typedef logic [`LA32_REG_AW-1:0] reg_addr_t;

  typedef enum logic [3:0] {
    NOP,
    ADD,
    SUB,
    SLT,
    SLTU,
    NOR,
    AND,
    OR,
    XOR,
    SLL,
    SRL,
    SRA,
    LUI
  } alu_op_e;

  // Result of an older instruction, offered for forwarding
  typedef struct packed {
    logic      we;
    reg_addr_t addr;
    word_t     data;
  } byp_t;

endpackage

`default_nettype wire

// ==== design/la32_pipe_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// Decode to operand fetch
interface dec_if;
  import la32_pkg::*;

  logic      valid;
  logic      illegal;
  alu_op_e   op;
  reg_addr_t rj_addr;
  reg_addr_t rk_addr;
  logic      rk_used;
  word_t     imm;
  reg_addr_t rd_addr;
  logic      rd_we;

  modport src (
    output valid, illegal, op, rj_addr, rk_addr, rk_used, imm, rd_addr, rd_we
  );

  modport dst (
    input valid, illegal, op, rj_addr, rk_addr, rk_used, imm, rd_addr, rd_we
  );
endinterface

// Operand fetch to execute
interface op_if;
  import la32_pkg::*;

  logic      valid;
  logic      illegal;
  alu_op_e   op;
  word_t     src_a;
  word_t     src_b;
  reg_addr_t rd_addr;
  logic      rd_we;

  modport src (
    output valid, illegal, op, src_a, src_b, rd_addr, rd_we
  );

  modport dst (
    input valid, illegal, op, src_a, src_b, rd_addr, rd_we
  );
endinterface

`default_nettype wire

// ==== design/la32_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "la32_macros.svh"

module la32_decoder (
  input  logic            clk,
  input  logic            rst_i,
  input  logic            inst_valid_i,
  input  la32_pkg::word_t inst_i,
  dec_if.src              dec
);
  import la32_pkg::*;

  typedef enum logic [2:0] {
    SEL_RK,
    SEL_SI12,
    SEL_UI12,
    SEL_UI5,
    SEL_HI20
  } imm_sel_e;

  typedef struct packed {
    word_t      pattern;
    logic [5:0] len;
    alu_op_e    op;
    imm_sel_e   sel;
  } dec_row_t;

  localparam int NROWS = 21;

  localparam dec_row_t TABLE [NROWS] = '{
    '{`LA32_OP_ADD_W,   `LA32_LEN_3R,    ADD,  SEL_RK},
    '{`LA32_OP_SUB_W,   `LA32_LEN_3R,    SUB,  SEL_RK},
    '{`LA32_OP_SLT,     `LA32_LEN_3R,    SLT,  SEL_RK},
    '{`LA32_OP_SLTU,    `LA32_LEN_3R,    SLTU, SEL_RK},
    '{`LA32_OP_NOR,     `LA32_LEN_3R,    NOR,  SEL_RK},
    '{`LA32_OP_AND,     `LA32_LEN_3R,    AND,  SEL_RK},
    '{`LA32_OP_OR,      `LA32_LEN_3R,    OR,   SEL_RK},
    '{`LA32_OP_XOR,     `LA32_LEN_3R,    XOR,  SEL_RK},
    '{`LA32_OP_SLL_W,   `LA32_LEN_3R,    SLL,  SEL_RK},
    '{`LA32_OP_SRL_W,   `LA32_LEN_3R,    SRL,  SEL_RK},
    '{`LA32_OP_SRA_W,   `LA32_LEN_3R,    SRA,  SEL_RK},
    '{`LA32_OP_SLLI_W,  `LA32_LEN_3R,    SLL,  SEL_UI5},
    '{`LA32_OP_SRLI_W,  `LA32_LEN_3R,    SRL,  SEL_UI5},
    '{`LA32_OP_SRAI_W,  `LA32_LEN_3R,    SRA,  SEL_UI5},
    '{`LA32_OP_SLTI,    `LA32_LEN_2RI12, SLT,  SEL_SI12},
    '{`LA32_OP_SLTUI,   `LA32_LEN_2RI12, SLTU, SEL_SI12},
    '{`LA32_OP_ADDI_W,  `LA32_LEN_2RI12, ADD,  SEL_SI12},
    '{`LA32_OP_ANDI,    `LA32_LEN_2RI12, AND,  SEL_UI12},
    '{`LA32_OP_ORI,     `LA32_LEN_2RI12, OR,   SEL_UI12},
    '{`LA32_OP_XORI,    `LA32_LEN_2RI12, XOR,  SEL_UI12},
    '{`LA32_OP_LU12I_W, `LA32_LEN_1RI20, LUI,  SEL_HI20}
  };

  logic        row_hit;
  alu_op_e     row_op;
  imm_sel_e    row_sel;
  word_t       imm_d;
  logic [11:0] si12;
  logic [4:0]  ui5;
  logic [19:0] si20;

  // Compare only the leading n bits of the word
  function automatic logic hit(word_t w, word_t pattern, logic [5:0] n);
    return (w >> (`LA32_XLEN - n)) == (pattern >> (`LA32_XLEN - n));
  endfunction

  assign si12 = inst_i[`LA32_F_SI12];
  assign ui5  = inst_i[`LA32_F_UI5];
  assign si20 = inst_i[`LA32_F_SI20];

  always_comb
  begin
    row_hit = 1'b0;
    row_op  = NOP;
    row_sel = SEL_RK;
    for (int i = 0; i < NROWS; i++)
    begin
      if (hit(inst_i, TABLE[i].pattern, TABLE[i].len))
      begin
        row_hit = 1'b1;
        row_op  = TABLE[i].op;
        row_sel = TABLE[i].sel;
      end
    end
  end

  always_comb
  begin
    case (row_sel)
      SEL_SI12: imm_d = {{(`LA32_XLEN-12){si12[11]}}, si12};
      SEL_UI12: imm_d = {{(`LA32_XLEN-12){1'b0}}, si12};
      SEL_UI5:  imm_d = {{(`LA32_XLEN-5){1'b0}}, ui5};
      SEL_HI20: imm_d = {si20, 12'b0};
      default:  imm_d = '0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst_i)
      dec.valid <= 1'b0;
    else
      dec.valid <= inst_valid_i;
  end

  always_ff @(posedge clk)
  begin
    if (inst_valid_i)
    begin
      dec.illegal <= !row_hit;
      dec.op      <= row_op;
      dec.rj_addr <= inst_i[`LA32_F_RJ];
      dec.rk_addr <= inst_i[`LA32_F_RK];
      dec.rk_used <= row_hit && (row_sel == SEL_RK);
      dec.imm     <= imm_d;
      dec.rd_addr <= inst_i[`LA32_F_RD];
      // r0 is never a destination
      dec.rd_we   <= row_hit && (inst_i[`LA32_F_RD] != '0);
    end
  end

endmodule

`default_nettype wire

// ==== design/la32_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "la32_macros.svh"

module la32_regfile (
  input  logic                clk,
  input  logic                rst_i,
  input  la32_pkg::reg_addr_t raddr_a_i,
  input  la32_pkg::reg_addr_t raddr_b_i,
  output la32_pkg::word_t     rdata_a_o,
  output la32_pkg::word_t     rdata_b_o,
  input  la32_pkg::byp_t      wr_i
);
  import la32_pkg::*;

  word_t regs [`LA32_NREGS];

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < `LA32_NREGS; i++)
        regs[i] <= '0;
    end
    // Entry 0 stays zero
    else if (wr_i.we && (wr_i.addr != '0))
      regs[wr_i.addr] <= wr_i.data;
  end

  assign rdata_a_o = regs[raddr_a_i];
  assign rdata_b_o = regs[raddr_b_i];

endmodule

`default_nettype wire

// ==== design/la32_operand_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module la32_operand_stage (
  input  logic                clk,
  input  logic                rst_i,
  dec_if.dst                  dec,
  output la32_pkg::reg_addr_t raddr_a_o,
  output la32_pkg::reg_addr_t raddr_b_o,
  input  la32_pkg::word_t     rdata_a_i,
  input  la32_pkg::word_t     rdata_b_i,
  input  la32_pkg::byp_t      ex_byp_i,
  input  la32_pkg::byp_t      wb_byp_i,
  op_if.src                   opnd
);
  import la32_pkg::*;

  word_t fwd_a;
  word_t fwd_b;

  // Newest producer first, register file last
  function automatic word_t resolve(
    reg_addr_t addr,
    word_t     rf_data,
    byp_t      ex,
    byp_t      wb
  );
    if (ex.we && (ex.addr == addr))
      return ex.data;
    else if (wb.we && (wb.addr == addr))
      return wb.data;
    else
      return rf_data;
  endfunction

  assign raddr_a_o = dec.rj_addr;
  assign raddr_b_o = dec.rk_addr;

  assign fwd_a = resolve(dec.rj_addr, rdata_a_i, ex_byp_i, wb_byp_i);
  assign fwd_b = dec.rk_used ? resolve(dec.rk_addr, rdata_b_i, ex_byp_i, wb_byp_i)
                             : dec.imm;

  always_ff @(posedge clk)
  begin
    if (rst_i)
      opnd.valid <= 1'b0;
    else
      opnd.valid <= dec.valid;
  end

  always_ff @(posedge clk)
  begin
    if (dec.valid)
    begin
      opnd.illegal <= dec.illegal;
      opnd.op      <= dec.op;
      opnd.src_a   <= fwd_a;
      opnd.src_b   <= fwd_b;
      opnd.rd_addr <= dec.rd_addr;
      opnd.rd_we   <= dec.rd_we;
    end
  end

endmodule

`default_nettype wire

// ==== design/la32_alu_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "la32_macros.svh"

module la32_alu_stage (
  input  logic           clk,
  input  logic           rst_i,
  op_if.dst              opnd,
  output la32_pkg::byp_t ex_byp_o,
  output la32_pkg::byp_t wb_byp_o,
  output logic           wb_valid_o,
  output logic           illegal_o
);
  import la32_pkg::*;

  localparam int SHW = $clog2(`LA32_XLEN);

  logic           ex_we;
  logic [SHW-1:0] shamt;
  word_t          res;
  logic           wb_we_q;
  reg_addr_t      wb_addr_q;
  word_t          wb_data_q;
  logic           illegal_q;

  assign shamt = opnd.src_b[SHW-1:0];
  assign ex_we = opnd.valid && opnd.rd_we;

  always_comb
  begin
    case (opnd.op)
      ADD:     res = opnd.src_a + opnd.src_b;
      SUB:     res = opnd.src_a - opnd.src_b;
      SLT:     res = word_t'($signed(opnd.src_a) < $signed(opnd.src_b));
      SLTU:    res = word_t'(opnd.src_a < opnd.src_b);
      NOR:     res = ~(opnd.src_a | opnd.src_b);
      AND:     res = opnd.src_a & opnd.src_b;
      OR:      res = opnd.src_a | opnd.src_b;
      XOR:     res = opnd.src_a ^ opnd.src_b;
      SLL:     res = opnd.src_a << shamt;
      SRL:     res = opnd.src_a >> shamt;
      SRA:     res = $signed(opnd.src_a) >>> shamt;
      // Upper immediate already placed by decode
      LUI:     res = opnd.src_b;
      default: res = '0;
    endcase
  end

  assign ex_byp_o = '{we: ex_we, addr: opnd.rd_addr, data: res};

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      wb_we_q   <= 1'b0;
      illegal_q <= 1'b0;
    end
    else
    begin
      wb_we_q   <= ex_we;
      illegal_q <= opnd.valid && opnd.illegal;
    end
  end

  always_ff @(posedge clk)
  begin
    if (ex_we)
    begin
      wb_addr_q <= opnd.rd_addr;
      wb_data_q <= res;
    end
  end

  assign wb_byp_o   = '{we: wb_we_q, addr: wb_addr_q, data: wb_data_q};
  assign wb_valid_o = wb_we_q;
  assign illegal_o  = illegal_q;

endmodule

`default_nettype wire

// ==== design/la32_int_pipe.sv ====
`timescale 1ns/100ps
`default_nettype none

module la32_int_pipe (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                inst_valid_i,
  input  la32_pkg::word_t     inst_i,
  output logic                wb_valid_o,
  output la32_pkg::reg_addr_t wb_addr_o,
  output la32_pkg::word_t     wb_data_o,
  output logic                illegal_o
);
  import la32_pkg::*;

  reg_addr_t raddr_a;
  reg_addr_t raddr_b;
  word_t     rdata_a;
  word_t     rdata_b;
  byp_t      ex_byp;
  byp_t      wb_byp;

  dec_if dec_bus ();
  op_if  op_bus ();

  la32_decoder u_decoder (
    .clk          (clk),
    .rst_i        (rst_i),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .dec          (dec_bus.src)
  );

  la32_operand_stage u_operand (
    .clk       (clk),
    .rst_i     (rst_i),
    .dec       (dec_bus.dst),
    .raddr_a_o (raddr_a),
    .raddr_b_o (raddr_b),
    .rdata_a_i (rdata_a),
    .rdata_b_i (rdata_b),
    .ex_byp_i  (ex_byp),
    .wb_byp_i  (wb_byp),
    .opnd      (op_bus.src)
  );

  la32_alu_stage u_alu (
    .clk        (clk),
    .rst_i      (rst_i),
    .opnd       (op_bus.dst),
    .ex_byp_o   (ex_byp),
    .wb_byp_o   (wb_byp),
    .wb_valid_o (wb_valid_o),
    .illegal_o  (illegal_o)
  );

  // Writeback slot feeds the write port
  la32_regfile u_regfile (
    .clk       (clk),
    .rst_i     (rst_i),
    .raddr_a_i (raddr_a),
    .raddr_b_i (raddr_b),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .wr_i      (wb_byp)
  );

  assign wb_addr_o = wb_byp.addr;
  assign wb_data_o = wb_byp.data;

endmodule

`default_nettype wire

// ==== testbench/la32_int_pipe_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module la32_int_pipe_props (
  input logic                clk,
  input logic                rst_i,
  input logic                wb_valid_o,
  input la32_pkg::reg_addr_t wb_addr_o,
  input logic                illegal_o
);

  // One writeback slot, so at most one kind of strobe
  a_one_strobe: assert property (
    @(posedge clk) disable iff (rst_i) !(wb_valid_o && illegal_o)
  )
    else $error("wb_valid_o and illegal_o are high in the same cycle");

  a_reset_quiet: assert property (
    @(posedge clk) rst_i |=> (!wb_valid_o && !illegal_o)
  )
    else $error("strobe seen in the cycle after reset");

  // r0 writes are dropped in decode
  a_no_r0_write: assert property (
    @(posedge clk) disable iff (rst_i) wb_valid_o |-> (wb_addr_o != '0)
  )
    else $error("writeback to r0 reported on wb_addr_o");

endmodule

bind la32_int_pipe la32_int_pipe_props props_i (
  .clk        (clk),
  .rst_i      (rst_i),
  .wb_valid_o (wb_valid_o),
  .wb_addr_o  (wb_addr_o),
  .illegal_o  (illegal_o)
);

`default_nettype wire

// ==== testbench/la32_int_pipe_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "la32_macros.svh"

module la32_int_pipe_tb;
  import la32_pkg::*;

  typedef enum logic [1:0] {K_IDLE, K_WRITE, K_ILLEGAL, K_SILENT} kind_e;

  typedef struct {
    string     name;
    word_t     inst;
    kind_e     kind;
    reg_addr_t rd;
    word_t     data;
  } row_t;

  logic      clk;
  logic      rst_i;
  logic      inst_valid_i;
  word_t     inst_i;
  logic      wb_valid_o;
  reg_addr_t wb_addr_o;
  word_t     wb_data_o;
  logic      illegal_o;

  row_t rows[$];
  int   expq[$];
  int   n_pass;
  int   n_fail;
  int   n_extra;
  bit   row_err;
  bit   table_done;

  la32_int_pipe dut_i (
    .clk          (clk),
    .rst_i        (rst_i),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .wb_valid_o   (wb_valid_o),
    .wb_addr_o    (wb_addr_o),
    .wb_data_o    (wb_data_o),
    .illegal_o    (illegal_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Register form, also used for ui5 shifts since ui5 sits in the rk field
  function automatic word_t asm_3r(word_t op, reg_addr_t rd, reg_addr_t rj, reg_addr_t rk);
    word_t w;
    w = op;
    w[`LA32_F_RD] = rd;
    w[`LA32_F_RJ] = rj;
    w[`LA32_F_RK] = rk;
    return w;
  endfunction

  function automatic word_t asm_ri12(word_t op, reg_addr_t rd, reg_addr_t rj, logic [11:0] imm);
    word_t w;
    w = op;
    w[`LA32_F_RD] = rd;
    w[`LA32_F_RJ] = rj;
    w[`LA32_F_SI12] = imm;
    return w;
  endfunction

  function automatic word_t asm_ri20(word_t op, reg_addr_t rd, logic [19:0] imm);
    word_t w;
    w = op;
    w[`LA32_F_RD] = rd;
    w[`LA32_F_SI20] = imm;
    return w;
  endfunction

  task automatic add_row(string name, word_t inst, kind_e kind, reg_addr_t rd, word_t data);
    row_t r;
    r.name = name;
    r.inst = inst;
    r.kind = kind;
    r.rd   = rd;
    r.data = data;
    rows.push_back(r);
  endtask

  task automatic check_word(string name, word_t exp, word_t act);
    if (exp !== act)
    begin
      $display("Mismatch %s: wb_data_o expected %h, actual %h", name, exp, act);
      row_err = 1'b1;
    end
  endtask

  task automatic check_addr(string name, reg_addr_t exp, reg_addr_t act);
    if (exp !== act)
    begin
      $display("Mismatch %s: wb_addr_o expected %0d, actual %0d", name, exp, act);
      row_err = 1'b1;
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (exp !== act)
    begin
      $display("Mismatch %s: expected %b, actual %b", name, exp, act);
      row_err = 1'b1;
    end
  endtask

  task automatic finish_row(string name);
    if (row_err)
    begin
      n_fail++;
      $display("FAIL %s", name);
    end
    else
    begin
      n_pass++;
      $display("PASS %s", name);
    end
  endtask

  // Match one output strobe against the oldest row that expects one
  task automatic take_strobe();
    row_t r;
    if (expq.size() == 0)
    begin
      $display("Unexpected strobe: wb_valid_o=%b illegal_o=%b with no instruction pending",
               wb_valid_o, illegal_o);
      n_extra++;
      n_fail++;
      return;
    end
    r = rows[expq.pop_front()];
    row_err = 1'b0;
    check_flag({r.name, " wb_valid_o"}, r.kind == K_WRITE, wb_valid_o);
    check_flag({r.name, " illegal_o"}, r.kind == K_ILLEGAL, illegal_o);
    if (r.kind == K_WRITE)
    begin
      check_addr(r.name, r.rd, wb_addr_o);
      check_word(r.name, r.data, wb_data_o);
    end
    finish_row(r.name);
  endtask

  always @(negedge clk)
  begin
    if (!rst_i && wb_valid_o && illegal_o)
    begin
      $display("Result and illegal strobes were both high at %0t", $time);
      n_fail++;
    end
    if (!rst_i && (wb_valid_o || illegal_o))
      take_strobe();
  end

  initial
  begin
    wait (table_done);
    #((rows.size() + 10) * 20);
    $display("Timeout: run did not finish within %0d cycles", rows.size() + 10);
    $display("Some tests failed");
    $finish;
  end

  initial
  begin
    int idx;
    rst_i        <= 1'b1;
    inst_valid_i <= 1'b0;
    inst_i       <= '0;
    n_pass  = 0;
    n_fail  = 0;
    n_extra = 0;

    add_row("idle_reset", '0, K_IDLE, 0, '0);
    add_row("lu12i_r1", asm_ri20(`LA32_OP_LU12I_W, 1, 20'h12345), K_WRITE, 1, 32'h1234_5000);
    add_row("ori_r1", asm_ri12(`LA32_OP_ORI, 1, 1, 12'h678), K_WRITE, 1, 32'h1234_5678);
    add_row("lu12i_r2", asm_ri20(`LA32_OP_LU12I_W, 2, 20'h80000), K_WRITE, 2, 32'h8000_0000);
    add_row("ori_zext", asm_ri12(`LA32_OP_ORI, 2, 2, 12'hfff), K_WRITE, 2, 32'h8000_0fff);
    add_row("addi_neg", asm_ri12(`LA32_OP_ADDI_W, 3, 0, 12'hffb), K_WRITE, 3, 32'hffff_fffb);
    add_row("andi_zext", asm_ri12(`LA32_OP_ANDI, 4, 3, 12'hf0f), K_WRITE, 4, 32'h0000_0f0b);
    add_row("xori_zext", asm_ri12(`LA32_OP_XORI, 5, 3, 12'h800), K_WRITE, 5, 32'hffff_f7fb);
    add_row("slti_true", asm_ri12(`LA32_OP_SLTI, 6, 3, 12'hffc), K_WRITE, 6, 32'h0000_0001);
    // -5 against -6, true if the immediate were zero-extended
    add_row("slti_false", asm_ri12(`LA32_OP_SLTI, 7, 3, 12'hffa), K_WRITE, 7, 32'h0000_0000);
    add_row("sltui_sext", asm_ri12(`LA32_OP_SLTUI, 8, 1, 12'hfff), K_WRITE, 8, 32'h0000_0001);
    add_row("add_w", asm_3r(`LA32_OP_ADD_W, 10, 1, 3), K_WRITE, 10, 32'h1234_5673);
    add_row("sub_w", asm_3r(`LA32_OP_SUB_W, 11, 1, 2), K_WRITE, 11, 32'h9234_4679);
    add_row("nor", asm_3r(`LA32_OP_NOR, 12, 1, 4), K_WRITE, 12, 32'hedcb_a084);
    add_row("and", asm_3r(`LA32_OP_AND, 13, 2, 5), K_WRITE, 13, 32'h8000_07fb);
    add_row("or", asm_3r(`LA32_OP_OR, 14, 1, 2), K_WRITE, 14, 32'h9234_5fff);
    add_row("xor", asm_3r(`LA32_OP_XOR, 15, 1, 3), K_WRITE, 15, 32'hedcb_a983);
    add_row("slt_opp", asm_3r(`LA32_OP_SLT, 16, 2, 1), K_WRITE, 16, 32'h0000_0001);
    add_row("sltu_opp", asm_3r(`LA32_OP_SLTU, 17, 2, 1), K_WRITE, 17, 32'h0000_0000);
    add_row("sll_w", asm_3r(`LA32_OP_SLL_W, 18, 1, 4), K_WRITE, 18, 32'ha2b3_c000);
    add_row("srl_w", asm_3r(`LA32_OP_SRL_W, 19, 2, 4), K_WRITE, 19, 32'h0010_0001);
    add_row("sra_w", asm_3r(`LA32_OP_SRA_W, 20, 2, 4), K_WRITE, 20, 32'hfff0_0001);
    add_row("slli_w", asm_3r(`LA32_OP_SLLI_W, 21, 1, 4), K_WRITE, 21, 32'h2345_6780);
    add_row("srli_w", asm_3r(`LA32_OP_SRLI_W, 22, 3, 28), K_WRITE, 22, 32'h0000_000f);
    add_row("srai_w", asm_3r(`LA32_OP_SRAI_W, 23, 3, 1), K_WRITE, 23, 32'hffff_fffd);
    // Each of the next three reads the result just ahead of it
    add_row("chain_0", asm_ri12(`LA32_OP_ADDI_W, 24, 0, 12'h100), K_WRITE, 24, 32'h0000_0100);
    add_row("chain_1", asm_3r(`LA32_OP_ADD_W, 24, 24, 24), K_WRITE, 24, 32'h0000_0200);
    add_row("chain_2", asm_3r(`LA32_OP_ADD_W, 24, 24, 24), K_WRITE, 24, 32'h0000_0400);
    add_row("chain_3", asm_3r(`LA32_OP_SUB_W, 25, 24, 1), K_WRITE, 25, 32'hedcb_ad88);
    // gap_c reads r26 from two instructions back
    add_row("gap_a", asm_ri12(`LA32_OP_ADDI_W, 26, 0, 12'h07f), K_WRITE, 26, 32'h0000_007f);
    add_row("gap_b", asm_ri12(`LA32_OP_ADDI_W, 27, 0, 12'h001), K_WRITE, 27, 32'h0000_0001);
    add_row("gap_c", asm_3r(`LA32_OP_ADD_W, 28, 26, 27), K_WRITE, 28, 32'h0000_0080);
    // beq r1, r1, 0
    add_row("illegal_beq", 32'h5800_0021, K_ILLEGAL, 1, '0);
    add_row("after_beq", asm_3r(`LA32_OP_OR, 29, 1, 0), K_WRITE, 29, 32'h1234_5678);
    add_row("write_r0", asm_ri12(`LA32_OP_ADDI_W, 0, 1, 12'h005), K_SILENT, 0, '0);
    add_row("read_r0", asm_3r(`LA32_OP_ADD_W, 31, 0, 0), K_WRITE, 31, 32'h0000_0000);
    add_row("idle_tail", '0, K_IDLE, 0, '0);
    table_done = 1'b1;

    repeat (2) @(posedge clk);
    rst_i <= 1'b0;

    for (int i = 0; i < rows.size(); i++)
    begin
      @(posedge clk);
      inst_valid_i <= (rows[i].kind != K_IDLE);
      inst_i       <= rows[i].inst;
      if (rows[i].kind == K_WRITE || rows[i].kind == K_ILLEGAL)
        expq.push_back(i);
    end
    @(posedge clk);
    inst_valid_i <= 1'b0;
    inst_i       <= '0;

    // Pipeline latency is three cycles; allow a little slack
    for (int k = 0; k < 5 && expq.size() != 0; k++)
      @(posedge clk);
    repeat (2) @(posedge clk);

    while (expq.size() != 0)
    begin
      idx = expq.pop_front();
      $display("Missing strobe: %s produced no output", rows[idx].name);
      n_fail++;
    end

    // Quiet rows pass only if no stray strobe appeared
    foreach (rows[i])
    begin
      if (rows[i].kind == K_IDLE || rows[i].kind == K_SILENT)
      begin
        row_err = (n_extra != 0);
        finish_row(rows[i].name);
      end
    end

    $display("Passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== la32_int_pipe.f ====
+incdir+design
design/la32_pkg.sv
design/la32_pipe_if.sv
design/la32_decoder.sv
design/la32_regfile.sv
design/la32_operand_stage.sv
design/la32_alu_stage.sv
design/la32_int_pipe.sv
testbench/la32_int_pipe_props.sv
testbench/la32_int_pipe_tb.sv
